// File: all.f
rv32i_types.sv
fetch_unit.sv
instr_queue.sv
frontend_top.sv
tb_imem.sv
tb_frontend.sv

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic                         clk,
	input  logic                         arst_n,
	// axi4-lite read address channel
	output logic [rv32i_types::XLEN-1:0] araddr,
	output logic                         arvalid,
	input  logic                         arready,
	// axi4-lite read data channel
	input  logic                         rvalid,
	output logic                         rready,
	input  logic [rv32i_types::XLEN-1:0] rdata,
	input  logic [1:0]                   rresp,
	// push side of the instruction queue
	output logic                         enq_valid,
	input  logic                         enq_ready,
	output logic [rv32i_types::XLEN-1:0] enq_pc,
	output logic [rv32i_types::XLEN-1:0] enq_instr,
	output rv32i_types::rv32_opcode_e    enq_opcode,
	// redirect from the back end
	input  logic                         flush_valid,
	input  logic [rv32i_types::XLEN-1:0] flush_pc
);
	import rv32i_types::*;

	typedef enum logic [1:0] {
		fetch_idle,
		fetch_addr,
		fetch_data
	} fetch_state_e;

	fetch_state_e    state;
	// next pc to request
	logic [XLEN-1:0] fetch_pc;
	// pc of the request on the bus
	logic [XLEN-1:0] req_pc;
	logic            drop_q;
	logic            ar_fire;
	logic            r_fire;
	logic [XLEN-1:0] start_pc;
	rv32_opcode_e    opcode_class;

	assign ar_fire = arvalid && arready;
	assign r_fire  = rvalid && rready;

	// a flush seen in idle redirects the request about to go out
	assign start_pc = flush_valid ? flush_pc : fetch_pc;

	assign arvalid = (state == fetch_addr);
	assign araddr  = req_pc;

	// stale beats are always taken
	// live beats wait for room in the queue
	assign rready = (state == fetch_data) && (drop_q || enq_ready);

	assign enq_valid  = (state == fetch_data) && rvalid && !drop_q;
	assign enq_pc     = req_pc;
	assign enq_instr  = rdata;
	assign enq_opcode = opcode_class;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= fetch_idle;
			fetch_pc <= RESET_PC;
			req_pc   <= RESET_PC;
			drop_q   <= 1'b0;
		end else begin
			case (state)
				fetch_idle: begin
					req_pc   <= start_pc;
					fetch_pc <= start_pc + XLEN'(4);
					state    <= fetch_addr;
				end
				fetch_addr: begin
					// araddr stays put, the answer gets thrown away
					if (flush_valid) begin
						fetch_pc <= flush_pc;
						drop_q   <= 1'b1;
					end
					if (ar_fire) begin
						state <= fetch_data;
					end
				end
				fetch_data: begin
					if (flush_valid) begin
						fetch_pc <= flush_pc;
					end
					if (r_fire) begin
						drop_q <= 1'b0;
						state  <= fetch_idle;
					end else if (flush_valid) begin
						drop_q <= 1'b1;
					end
				end
				default: begin
					state <= fetch_idle;
				end
			endcase
		end
	end

	// rresp is not decoded, every beat counts as okay
	always_comb begin
		case (rdata[6:0])
			OPC_LUI:    opcode_class = op_lui;
			OPC_AUIPC:  opcode_class = op_auipc;
			OPC_JAL:    opcode_class = op_jal;
			OPC_JALR:   opcode_class = op_jalr;
			OPC_BRANCH: opcode_class = op_br;
			OPC_LOAD:   opcode_class = op_load;
			OPC_STORE:  opcode_class = op_store;
			OPC_IMM:    opcode_class = op_imm;
			OPC_REG:    opcode_class = op_reg;
			OPC_SYSTEM: opcode_class = op_csr;
			default:    opcode_class = op_illegal;
		endcase
	end

	// AR payload held until the slave takes it
	a_araddr_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		arvalid && !arready |=> arvalid && $stable(araddr)
	) else $error("araddr moved while the AR request was pending");

	// flushed read never reaches the queue
	a_drop_no_push: assert property (
		@(posedge clk) disable iff (!arst_n)
		flush_valid && (state == fetch_addr || (state == fetch_data && !r_fire))
		|=> !enq_valid until_with r_fire
	) else $error("stale read response pushed after a flush");

	// slave keeps the beat steady while we stall it
	a_r_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable({rresp, rdata})
	) else $error("R beat changed while rready was low");

endmodule

// File: frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
	input  logic                         clk,
	input  logic                         arst_n,
	// axi4-lite read port to instruction memory
	output logic [rv32i_types::XLEN-1:0] araddr,
	output logic                         arvalid,
	input  logic                         arready,
	input  logic                         rvalid,
	output logic                         rready,
	input  logic [rv32i_types::XLEN-1:0] rdata,
	input  logic [1:0]                   rresp,
	// redirect
	input  logic                         flush_valid,
	input  logic [rv32i_types::XLEN-1:0] flush_pc,
	// decode side
	output logic                         deq_valid,
	input  logic                         deq_ready,
	output logic [rv32i_types::XLEN-1:0] deq_pc,
	output logic [rv32i_types::XLEN-1:0] deq_instr,
	output rv32i_types::rv32_opcode_e    deq_opcode
);
	import rv32i_types::*;

	// fetch to queue push channel
	logic            enq_valid;
	logic            enq_ready;
	logic [XLEN-1:0] enq_pc;
	logic [XLEN-1:0] enq_instr;
	rv32_opcode_e    enq_opcode;

	fetch_unit fetch_unit_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rvalid      (rvalid),
		.rready      (rready),
		.rdata       (rdata),
		.rresp       (rresp),
		.enq_valid   (enq_valid),
		.enq_ready   (enq_ready),
		.enq_pc      (enq_pc),
		.enq_instr   (enq_instr),
		.enq_opcode  (enq_opcode),
		.flush_valid (flush_valid),
		.flush_pc    (flush_pc)
	);

	// flush_pc only matters to fetch
	instr_queue instr_queue_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.enq_valid   (enq_valid),
		.enq_ready   (enq_ready),
		.enq_pc      (enq_pc),
		.enq_instr   (enq_instr),
		.enq_opcode  (enq_opcode),
		.deq_valid   (deq_valid),
		.deq_ready   (deq_ready),
		.deq_pc      (deq_pc),
		.deq_instr   (deq_instr),
		.deq_opcode  (deq_opcode),
		.flush_valid (flush_valid)
	);

endmodule

// File: instr_queue.sv
`timescale 1ns/1ps

module instr_queue (
	input  logic                         clk,
	input  logic                         arst_n,
	// push side from fetch
	input  logic                         enq_valid,
	output logic                         enq_ready,
	input  logic [rv32i_types::XLEN-1:0] enq_pc,
	input  logic [rv32i_types::XLEN-1:0] enq_instr,
	input  rv32i_types::rv32_opcode_e    enq_opcode,
	// pop side to decode
	output logic                         deq_valid,
	input  logic                         deq_ready,
	output logic [rv32i_types::XLEN-1:0] deq_pc,
	output logic [rv32i_types::XLEN-1:0] deq_instr,
	output rv32i_types::rv32_opcode_e    deq_opcode,
	// clears everything in one edge
	input  logic                         flush_valid
);
	import rv32i_types::*;

	pci_t                mem [IQ_DEPTH];
	// oldest entry
	logic [IQ_PTR_W-1:0] front;
	// next free slot
	logic [IQ_PTR_W-1:0] rear;
	logic [IQ_PTR_W:0]   count;
	logic                full;
	logic                push;
	logic                pop;
	pci_t                head;

	function automatic logic [IQ_PTR_W-1:0] ptr_inc(input logic [IQ_PTR_W-1:0] ptr);
		if (ptr == IQ_PTR_W'(IQ_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full      = (count == (IQ_PTR_W + 1)'(IQ_DEPTH));
	assign enq_ready = !full;
	assign deq_valid = (count != '0);

	// nothing moves in a flush cycle
	assign push = enq_valid && enq_ready && !flush_valid;
	assign pop  = deq_valid && deq_ready && !flush_valid;

	// head comes straight out of the array, no bypass
	assign head       = mem[front];
	assign deq_pc     = head.pc;
	assign deq_instr  = head.instr;
	assign deq_opcode = head.opcode;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			front <= '0;
			rear  <= '0;
			count <= '0;
		end else if (flush_valid) begin
			front <= '0;
			rear  <= '0;
			count <= '0;
		end else begin
			if (push) begin
				rear <= ptr_inc(rear);
			end
			if (pop) begin
				front <= ptr_inc(front);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// push and pop never hit the same slot
	// a full queue refuses pushes and an empty one has nothing to pop
	always_ff @(posedge clk) begin
		if (push) begin
			mem[rear] <= '{pc: enq_pc, instr: enq_instr, opcode: enq_opcode};
		end
		// freed slot goes back to a nop
		if (pop) begin
			mem[front] <= IQ_NOP;
		end
	end

	// last free slot taken, so the next push is refused
	a_full_refuse: assert property (
		@(posedge clk) disable iff (!arst_n)
		push && !pop && (count == (IQ_PTR_W + 1)'(IQ_DEPTH - 1)) |=> !enq_ready
	) else $error("queue still accepts pushes after filling up");

	// queue drained or flushed, head must drop
	a_empty_no_valid: assert property (
		@(posedge clk) disable iff (!arst_n)
		flush_valid || (pop && !push && count == 1) |=> !deq_valid
	) else $error("deq_valid high on an empty queue");

	// stalled head does not change under decode
	a_head_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		deq_valid && !deq_ready && !flush_valid |=> deq_valid && $stable(head)
	) else $error("queue head changed while decode stalled it");

endmodule

// File: rv32i_types.sv
package rv32i_types;

	// data and address width
	localparam int XLEN = 32;

	// first fetch address out of reset
	localparam logic [XLEN-1:0] RESET_PC = '0;

	// instruction queue geometry
	localparam int IQ_DEPTH = 8;
	localparam int IQ_PTR_W = $clog2(IQ_DEPTH);

	// base opcodes, bits 6:0 of an rv32i word
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_REG    = 7'b0110011;
	// csr access and ecall/ebreak share this one
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// coarse instruction class handed to decode
	typedef enum logic [3:0] {
		op_lui,
		op_auipc,
		op_jal,
		op_jalr,
		op_br,
		op_load,
		op_store,
		op_imm,
		op_reg,
		op_csr,
		op_illegal
	} rv32_opcode_e;

	// one queue entry, 68 bits
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instr;
		rv32_opcode_e    opcode;
	} pci_t;

	// addi x0, x0, 0 written into freed slots
	localparam pci_t IQ_NOP = '{
		pc:     '0,
		instr:  {{(XLEN-7){1'b0}}, OPC_IMM},
		opcode: op_imm
	};

endpackage

// File: tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;
	import rv32i_types::*;

	localparam int SEQ_POPS   = 200;
	localparam int OPC_POPS   = 160;
	localparam int BP_POPS    = 500;
	localparam int FLUSHES    = 12;
	localparam int FLUSH_GAP  = 40;
	localparam int STALL_LEN  = 20;
	// reset plus the length of each test
	localparam int RUN_CYCLES = 10 + SEQ_POPS + OPC_POPS + BP_POPS + FLUSHES * FLUSH_GAP;

	typedef enum logic [2:0] {drv_idle, drv_stream, drv_fill, drv_pressure, drv_flush} drive_e;

	logic            clk;
	logic            arst_n;
	logic [XLEN-1:0] araddr;
	logic            arvalid;
	logic            arready;
	logic            rvalid;
	logic            rready;
	logic [XLEN-1:0] rdata;
	logic [1:0]      rresp;
	logic            flush_valid;
	logic [XLEN-1:0] flush_pc;
	logic            deq_valid;
	logic            deq_ready;
	logic [XLEN-1:0] deq_pc;
	logic [XLEN-1:0] deq_instr;
	rv32_opcode_e    deq_opcode;

	integer          seed = 78;
	drive_e          mode;
	string           test_name;
	int              err_count;
	int              test_errs;
	int              tests_run;
	int              tests_failed;
	int              target;
	int              pop_count;
	int              flush_count;
	int              flush_on_read;
	int              stall_left;
	int              occ;
	int              max_occ;
	int              illegal_seen;
	logic [15:0]     slots_seen;
	logic [XLEN-1:0] exp_pc;
	logic            outstanding;
	logic            drop_next;
	logic            redirect_pending;
	logic            held;
	pci_t            held_entry;

	frontend_top frontend_top_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rvalid      (rvalid),
		.rready      (rready),
		.rdata       (rdata),
		.rresp       (rresp),
		.flush_valid (flush_valid),
		.flush_pc    (flush_pc),
		.deq_valid   (deq_valid),
		.deq_ready   (deq_ready),
		.deq_pc      (deq_pc),
		.deq_instr   (deq_instr),
		.deq_opcode  (deq_opcode)
	);

	tb_imem imem_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rvalid  (rvalid),
		.rready  (rready),
		.rdata   (rdata),
		.rresp   (rresp)
	);

	// slot at pc bits 5:2 gives the low opcode bits and their class
	function automatic logic [10:0] table_entry(input logic [3:0] slot);
		case (slot)
			4'd0:    return {7'b0110111, op_lui};
			4'd1:    return {7'b0010111, op_auipc};
			4'd2:    return {7'b1101111, op_jal};
			4'd3:    return {7'b1100111, op_jalr};
			4'd4:    return {7'b1100011, op_br};
			4'd5:    return {7'b0000011, op_load};
			4'd6:    return {7'b0100011, op_store};
			4'd7:    return {7'b0010011, op_imm};
			4'd8:    return {7'b0110011, op_reg};
			4'd9:    return {7'b1110011, op_csr};
			4'd10:   return {7'b0000000, op_illegal};
			4'd11:   return {7'b1111111, op_illegal};
			4'd12:   return {7'b0001111, op_illegal};
			4'd13:   return {7'b0101111, op_illegal};
			4'd14:   return {7'b1010011, op_illegal};
			default: return {7'b1110111, op_illegal};
		endcase
	endfunction

	function automatic logic [XLEN-1:0] expected_word(input logic [XLEN-1:0] pc);
		logic [10:0] entry;
		entry = table_entry(pc[5:2]);
		return {pc[XLEN-1:7], entry[10:4]};
	endfunction

	function automatic rv32_opcode_e expected_class(input logic [XLEN-1:0] pc);
		logic [10:0] entry;
		entry = table_entry(pc[5:2]);
		return rv32_opcode_e'(entry[3:0]);
	endfunction

	task automatic check_pc(input string name, input logic [XLEN-1:0] exp,
			input logic [XLEN-1:0] act);
		if (act !== exp) begin
			err_count++;
			$display("ERR %s: pc expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_instr(input string name, input logic [XLEN-1:0] exp,
			input logic [XLEN-1:0] act);
		if (act !== exp) begin
			err_count++;
			$display("ERR %s: instr expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_opcode(input string name, input rv32_opcode_e exp,
			input rv32_opcode_e act);
		if (act !== exp) begin
			err_count++;
			$display("ERR %s: opcode expected %0d, got %0d", name, exp, act);
		end
	endtask

	task automatic report_problem(input string what);
		err_count++;
		$display("%s: %s", test_name, what);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = err_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (err_count != test_errs) begin
			tests_failed++;
		end
		$display("%-18s %s, %0d errors", test_name,
			(err_count == test_errs) ? "pass" : "fail", err_count - test_errs);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// decode back-pressure and redirects
	always @(posedge clk) begin
		case (mode)
			drv_stream: begin
				deq_ready   <= 1'b1;
				flush_valid <= 1'b0;
			end
			drv_pressure, drv_flush: begin
				if (stall_left > 0) begin
					stall_left = stall_left - 1;
					deq_ready  <= 1'b0;
				end else if (mode == drv_pressure && $unsigned($random(seed)) % 50 == 0) begin
					stall_left = STALL_LEN - 1;
					deq_ready  <= 1'b0;
				end else begin
					deq_ready <= ($unsigned($random(seed)) % 4) != 0;
				end
				if (mode == drv_flush && $unsigned($random(seed)) % FLUSH_GAP == 0) begin
					flush_valid <= 1'b1;
					flush_pc    <= $random(seed) & ~32'h3;
				end else begin
					flush_valid <= 1'b0;
				end
			end
			default: begin
				deq_ready   <= 1'b0;
				flush_valid <= 1'b0;
			end
		endcase
	end

	// reference model, sampled mid-cycle for the coming edge
	always @(negedge clk) begin
		if (arst_n) begin
			if (held) begin
				if (!deq_valid) begin
					report_problem("deq_valid dropped while decode held the head");
				end else begin
					check_pc({test_name, " hold"}, held_entry.pc, deq_pc);
					check_instr({test_name, " hold"}, held_entry.instr, deq_instr);
					check_opcode({test_name, " hold"}, held_entry.opcode, deq_opcode);
				end
			end
			held       = deq_valid && !deq_ready && !flush_valid;
			held_entry = '{pc: deq_pc, instr: deq_instr, opcode: deq_opcode};
			if (flush_valid) begin
				// a read still in flight comes back and is thrown away
				drop_next = arvalid || (outstanding && !(rvalid && rready));
				if (drop_next) begin
					flush_on_read++;
				end
				flush_count++;
				exp_pc           = flush_pc;
				redirect_pending = 1'b1;
				occ              = 0;
			end else begin
				if (deq_valid && deq_ready) begin
					check_pc(test_name, exp_pc, deq_pc);
					check_instr(test_name, expected_word(exp_pc), deq_instr);
					check_opcode(test_name, expected_class(exp_pc), deq_opcode);
					slots_seen[deq_pc[5:2]] = 1'b1;
					if (deq_opcode == op_illegal) begin
						illegal_seen++;
					end
					redirect_pending = 1'b0;
					exp_pc           = exp_pc + 32'd4;
					pop_count++;
					occ--;
				end
				// a stale beat is taken at once, whatever the queue holds
				if (drop_next && rvalid && !rready) begin
					report_problem("stale read response stalled instead of taken");
				end
				if (rvalid && rready) begin
					if (drop_next) begin
						drop_next = 1'b0;
					end else begin
						occ++;
					end
				end
				max_occ = (occ > max_occ) ? occ : max_occ;
				if (occ > IQ_DEPTH) begin
					report_problem("queue took more entries than it holds");
				end
			end
			if (arvalid && arready) begin
				outstanding = 1'b1;
			end else if (rvalid && rready) begin
				outstanding = 1'b0;
			end
		end
	end

	initial begin
		arst_n           = 1'b0;
		flush_valid      = 1'b0;
		flush_pc         = '0;
		deq_ready        = 1'b0;
		mode             = drv_idle;
		exp_pc           = RESET_PC;
		outstanding      = 1'b0;
		drop_next        = 1'b0;
		redirect_pending = 1'b0;
		held             = 1'b0;
		slots_seen       = '0;

		begin_test("reset");
		repeat (5) begin
			@(negedge clk);
			if (arvalid || deq_valid) begin
				report_problem("arvalid or deq_valid high during reset");
			end
		end
		@(posedge clk);
		arst_n <= 1'b1;
		while (!arvalid) @(negedge clk);
		check_pc(test_name, RESET_PC, araddr);
		end_test();

		begin_test("sequential fetch");
		@(posedge clk);
		mode <= drv_stream;
		target = pop_count + SEQ_POPS;
		while (pop_count < target) @(posedge clk);
		end_test();

		begin_test("opcode classes");
		slots_seen   = '0;
		illegal_seen = 0;
		target       = pop_count + OPC_POPS;
		while (pop_count < target) @(posedge clk);
		if (slots_seen != 16'hffff || illegal_seen == 0) begin
			report_problem("not every table slot was popped");
		end
		end_test();

		// fill the queue first, then random stalls
		begin_test("back-pressure");
		max_occ = 0;
		mode <= drv_fill;
		while (occ < IQ_DEPTH) @(posedge clk);
		repeat (STALL_LEN) @(posedge clk);
		mode <= drv_pressure;
		target = pop_count + BP_POPS;
		while (pop_count < target) @(posedge clk);
		if (max_occ != IQ_DEPTH) begin
			report_problem("queue never reached full occupancy");
		end
		end_test();

		begin_test("flush redirect");
		mode <= drv_flush;
		while (flush_count < FLUSHES) @(posedge clk);
		mode <= drv_stream;
		repeat (2) @(posedge clk);
		while (redirect_pending) @(posedge clk);
		if (flush_on_read == 0) begin
			report_problem("no flush landed on an outstanding read");
		end
		end_test();

		$display("tests %0d, failed %0d, pops %0d, flushes %0d, errors %0d",
			tests_run, tests_failed, pop_count, flush_count, err_count);
		if (err_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		repeat (RUN_CYCLES * 20) @(posedge clk);
		$display("timeout: run still busy after %0d cycles", RUN_CYCLES * 20);
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: tb_imem.sv
`timescale 1ns/1ps

module tb_imem (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic [rv32i_types::XLEN-1:0] araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic                         rvalid,
	input  logic                         rready,
	output logic [rv32i_types::XLEN-1:0] rdata,
	output logic [1:0]                   rresp
);
	import rv32i_types::*;

	integer          seed = 78;
	logic [1:0]      ar_wait;
	logic [2:0]      r_wait;
	logic            r_pend;
	logic [XLEN-1:0] addr_q;

	// low seven bits of a word, picked by address bits 5:2
	function automatic logic [6:0] opcode_bits(input logic [3:0] slot);
		case (slot)
			4'd0:    return 7'b0110111;
			4'd1:    return 7'b0010111;
			4'd2:    return 7'b1101111;
			4'd3:    return 7'b1100111;
			4'd4:    return 7'b1100011;
			4'd5:    return 7'b0000011;
			4'd6:    return 7'b0100011;
			4'd7:    return 7'b0010011;
			4'd8:    return 7'b0110011;
			4'd9:    return 7'b1110011;
			4'd10:   return 7'b0000000;
			4'd11:   return 7'b1111111;
			4'd12:   return 7'b0001111;
			4'd13:   return 7'b0101111;
			4'd14:   return 7'b1010011;
			default: return 7'b1110111;
		endcase
	endfunction

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
			rresp   <= '0;
			r_pend  <= 1'b0;
			r_wait  <= '0;
			ar_wait <= 2'($unsigned($random(seed)) % 4);
			addr_q  <= '0;
		end else begin
			// address phase, 0 to 3 wait cycles
			if (arvalid && arready) begin
				arready <= 1'b0;
				addr_q  <= araddr;
				r_wait  <= 3'($unsigned($random(seed)) % 5);
				r_pend  <= 1'b1;
			end else if (arvalid) begin
				if (ar_wait == '0) begin
					arready <= 1'b1;
				end else begin
					ar_wait <= ar_wait - 1'b1;
				end
			end
			// data phase, 0 to 4 more cycles
			if (r_pend) begin
				if (r_wait == '0) begin
					rvalid <= 1'b1;
					rdata  <= {addr_q[XLEN-1:7], opcode_bits(addr_q[5:2])};
					rresp  <= 2'($random(seed));
					r_pend <= 1'b0;
				end else begin
					r_wait <= r_wait - 1'b1;
				end
			end
			if (rvalid && rready) begin
				rvalid  <= 1'b0;
				ar_wait <= 2'($unsigned($random(seed)) % 4);
			end
		end
	end

endmodule
